/* ipb_top.f */
src/ipb_pkg.sv
src/ipb_ctrl.sv
src/ipb_addr_gen.sv
src/ipb_line_buf.sv
src/ipb_resp_route.sv
src/ipb_top.sv
tests/tb_clk_gen.sv
tests/tb_ipb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the prefetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_ipb \
    --Mdir obj_dir -o sim_ipb -f ipb_top.f > build.log 2>&1; then
  echo "verilator build failed, see build.log"
  exit 1
fi

if ! ./obj_dir/sim_ipb > sim.log 2>&1; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* src/ipb_addr_gen.sv */
/*
  prefetch address generation
  holds the prefetched line address, checks page boundary and
  refill hit, and drives the bus read address, id and length
*/
module ipb_addr_gen #(
  parameter int ADDR_W = 40
) (
  input  logic              pref_clk,
  input  logic              cpurst_b,
  input  logic [ADDR_W-1:0] refill_addr,
  input  logic              refill_line,
  input  logic              ref_sel,
  input  logic              pref_launch,
  output logic [ADDR_W-1:0] bus_addr,
  output logic              bus_id,
  output logic [1:0]        bus_len,
  output logic              ref_hit_pref,
  output logic              within_page
);
  import ipb_pkg::*;

  localparam int LINE_W = ADDR_W - LINE_OFS_W;

  logic [LINE_W-1:0] ref_line_addr;
  logic [LINE_W-1:0] next_line_addr;
  logic [LINE_W-1:0] pref_line_addr;

  assign ref_line_addr  = refill_addr[ADDR_W-1:LINE_OFS_W];
  assign next_line_addr = ref_line_addr + 1'b1;

  // last line of a 4 KB page has all line bits set
  assign within_page = ~&refill_addr[PAGE_OFS_W-1:LINE_OFS_W];

  // captured in the refill grant cycle that launches
  always_ff @(posedge pref_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pref_line_addr <= '0;
    else if (pref_launch)
      pref_line_addr <= next_line_addr;
  end

  // only a full-line refill can be served from the buffer
  assign ref_hit_pref = refill_line && (ref_line_addr == pref_line_addr);

  //============================================================
  // bus read address mux
  //============================================================
  // refill is beat aligned, prefetch is line aligned
  assign bus_addr = ref_sel ? {refill_addr[ADDR_W-1:BEAT_OFS_W], {BEAT_OFS_W{1'b0}}}
                            : {pref_line_addr, {LINE_OFS_W{1'b0}}};
  assign bus_id   = ref_sel ? ID_REFILL : ID_PREF;
  assign bus_len  = (!ref_sel || refill_line) ? LEN_LINE : LEN_SINGLE;

endmodule

/* src/ipb_ctrl.sv */
/*
  prefetch buffer control
  prefetch request FSM, writeback FSM, launch decision,
  bus grant split between refill and prefetch, line buffer
  write strobes
*/
module ipb_ctrl (
  input  logic                           pref_clk,
  input  logic                           cpurst_b,
  input  logic                           refill_req,
  input  logic                           refill_on,
  input  logic                           refill_line,
  input  logic                           pref_en,
  input  logic                           inv_on,
  input  logic                           bus_grnt,
  input  logic                           ref_hit_pref,
  input  logic                           within_page,
  input  logic                           pref_beat,
  input  logic                           pref_err,
  input  logic                           pref_last,
  output logic                           ref_sel,
  output logic                           bus_req,
  output logic                           pref_launch,
  output logic                           refill_grnt,
  output logic                           buf_wen,
  output logic [ipb_pkg::BEAT_IDX_W-1:0] buf_widx,
  output logic                           wb_load,
  output logic                           wb_active,
  output logic                           wb_step,
  output logic                           pref_idle
);
  import ipb_pkg::*;

  logic [2:0] req_st;
  logic [2:0] req_nxt;
  logic [2:0] wb_st;
  logic [2:0] wb_nxt;
  logic       ref_grnt;
  logic       pf_grnt;
  logic       pref_cmplt;

  //============================================================
  // bus arbitration and launch
  //============================================================
  assign pref_idle = (req_st == REQ_IDLE) && (wb_st == WB_IDLE);
  // refill owns the bus unless it targets the held line
  assign ref_sel   = refill_req && (pref_idle || !ref_hit_pref);
  assign bus_req   = ref_sel || (req_st == REQ_PF_REQ);
  assign ref_grnt  = bus_grnt && ref_sel;
  assign pf_grnt   = bus_grnt && !ref_sel;

  // next-line prefetch only behind a granted line refill
  assign pref_launch = ref_grnt && pref_idle && refill_line && refill_on
                    && pref_en && !inv_on && within_page;

  // local grant from the writeback machine
  assign refill_grnt = ref_grnt || (wb_st == WB_GRNT);

  //============================================================
  // prefetch request FSM
  //============================================================
  always_ff @(posedge pref_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      req_st <= REQ_IDLE;
    else
      req_st <= req_nxt;
  end

  always_comb
  begin
    req_nxt = req_st;
    case (req_st)
      REQ_IDLE:
        if (pref_launch)
          req_nxt = REQ_PF_REQ;
      REQ_PF_REQ:
      begin
        // refill to another line cancels a waiting request
        if (pf_grnt)
          req_nxt = REQ_PF0;
        else if (refill_req && !ref_hit_pref)
          req_nxt = REQ_IDLE;
      end
      REQ_PF0, REQ_PF1, REQ_PF2:
      begin
        if (pref_err)
          req_nxt = REQ_INV;
        else if (pref_beat)
          req_nxt = {1'b1, req_st[1:0] + 2'd1};
      end
      REQ_PF3:
        // error on the last beat ends without completion
        if (pref_err || pref_beat)
          req_nxt = REQ_IDLE;
      REQ_INV:
        // drain the remaining beats of a failed burst
        if (pref_last)
          req_nxt = REQ_IDLE;
      default:
        req_nxt = REQ_IDLE;
    endcase
  end

  // PFn states hold the beat index in the low bits
  assign buf_wen    = req_st[2] && pref_beat;
  assign buf_widx   = req_st[BEAT_IDX_W-1:0];
  assign pref_cmplt = (req_st == REQ_PF3) && pref_beat;

  //============================================================
  // writeback FSM
  //============================================================
  always_ff @(posedge pref_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_st <= WB_IDLE;
    else
      wb_st <= wb_nxt;
  end

  always_comb
  begin
    wb_nxt = wb_st;
    case (wb_st)
      WB_IDLE, WB_VLD:
      begin
        // line is usable once complete or already held
        if (inv_on)
          wb_nxt = WB_IDLE;
        else if ((wb_st == WB_VLD) || pref_cmplt)
        begin
          if (refill_req && ref_hit_pref)
            wb_nxt = WB_GRNT;
          else if (refill_req)
            wb_nxt = WB_IDLE;
          else
            wb_nxt = WB_VLD;
        end
      end
      WB_GRNT: wb_nxt = WB_WB0;
      WB_WB0:  wb_nxt = WB_WB1;
      WB_WB1:  wb_nxt = WB_WB2;
      WB_WB2:  wb_nxt = WB_WB3;
      WB_WB3:  wb_nxt = WB_IDLE;
      default: wb_nxt = WB_IDLE;
    endcase
  end

  // pointer loads during grant, then walks the beats
  assign wb_load   = (wb_st == WB_GRNT);
  assign wb_active = wb_st[2];
  assign wb_step   = wb_active && (wb_st != WB_WB3);

endmodule

/* src/ipb_line_buf.sv */
/*
  prefetch line buffer
  four beat registers filled by index from the bus, read back
  through a wrapping pointer that starts at the critical beat
*/
module ipb_line_buf #(
  parameter int DATA_W = 128
) (
  input  logic                           pref_clk,
  input  logic                           cpurst_b,
  input  logic                           buf_wen,
  input  logic [ipb_pkg::BEAT_IDX_W-1:0] buf_widx,
  input  logic [DATA_W-1:0]              bus_rdata,
  input  logic                           wb_load,
  input  logic                           wb_step,
  input  logic [ipb_pkg::BEAT_IDX_W-1:0] refill_offset,
  output logic [DATA_W-1:0]              wb_rdata
);
  import ipb_pkg::*;

  localparam int NUM_BEATS = 1 << BEAT_IDX_W;

  logic [DATA_W-1:0]     beat_q [NUM_BEATS];
  logic [BEAT_IDX_W-1:0] rd_ptr;

  // beat storage
  always_ff @(posedge pref_clk)
  begin
    if (buf_wen)
      beat_q[buf_widx] <= bus_rdata;
  end

  //============================================================
  // critical word first read pointer
  //============================================================
  always_ff @(posedge pref_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rd_ptr <= '0;
    else if (wb_load)
      rd_ptr <= refill_offset;
    else if (wb_step)
      // natural wrap at the line end
      rd_ptr <= rd_ptr + 1'b1;
  end

  assign wb_rdata = beat_q[rd_ptr];

endmodule

/* src/ipb_pkg.sv */
/*
  instruction prefetch buffer shared definitions
  line, beat and page geometry, state encodings of the
  prefetch request and writeback machines, bus id and length codes
*/
package ipb_pkg;

  // address geometry
  localparam int unsigned LINE_OFS_W = 6;
  localparam int unsigned BEAT_OFS_W = 4;
  localparam int unsigned PAGE_OFS_W = 12;
  // four beats per line
  localparam int unsigned BEAT_IDX_W = 2;

  // PFn request states carry the beat index in [1:0]
  localparam logic [2:0] REQ_IDLE   = 3'b000;
  localparam logic [2:0] REQ_PF_REQ = 3'b001;
  localparam logic [2:0] REQ_INV    = 3'b010;
  localparam logic [2:0] REQ_PF0    = 3'b100;
  localparam logic [2:0] REQ_PF1    = 3'b101;
  localparam logic [2:0] REQ_PF2    = 3'b110;
  localparam logic [2:0] REQ_PF3    = 3'b111;

  // bit 2 marks the WBn writeback beats
  localparam logic [2:0] WB_IDLE = 3'b000;
  localparam logic [2:0] WB_VLD  = 3'b001;
  localparam logic [2:0] WB_GRNT = 3'b011;
  localparam logic [2:0] WB_WB0  = 3'b110;
  localparam logic [2:0] WB_WB1  = 3'b111;
  localparam logic [2:0] WB_WB2  = 3'b101;
  localparam logic [2:0] WB_WB3  = 3'b100;

  // bus read id and burst length
  localparam logic       ID_REFILL  = 1'b0;
  localparam logic       ID_PREF    = 1'b1;
  localparam logic [1:0] LEN_LINE   = 2'd3;
  localparam logic [1:0] LEN_SINGLE = 2'd0;

endpackage

/* src/ipb_resp_route.sv */
/*
  bus response routing
  splits read beats by id and error between the prefetcher and
  the refill side, and merges buffer data during writeback
*/
module ipb_resp_route #(
  parameter int DATA_W = 128
) (
  input  logic              bus_rvalid,
  input  logic              bus_rid,
  input  logic              bus_rlast,
  input  logic              bus_rerr,
  input  logic [DATA_W-1:0] bus_rdata,
  input  logic              wb_active,
  input  logic [DATA_W-1:0] wb_rdata,
  output logic              pref_beat,
  output logic              pref_err,
  output logic              pref_last,
  output logic              refill_rvalid,
  output logic [DATA_W-1:0] refill_rdata,
  output logic              refill_rerr
);
  import ipb_pkg::*;

  logic pref_rsp;
  logic ref_rsp;

  assign pref_rsp = bus_rvalid && (bus_rid == ID_PREF);
  assign ref_rsp  = bus_rvalid && (bus_rid == ID_REFILL);

  // prefetch last flag also marks a failed burst end
  assign pref_beat = pref_rsp && !bus_rerr;
  assign pref_err  = pref_rsp && bus_rerr;
  assign pref_last = pref_rsp && bus_rlast;

  // buffer beats take the refill data path in writeback
  assign refill_rvalid = wb_active || (ref_rsp && !bus_rerr);
  assign refill_rerr   = ref_rsp && bus_rerr;
  assign refill_rdata  = wb_active ? wb_rdata : bus_rdata;

endmodule

/* src/ipb_top.sv */
/*
  instruction prefetch buffer
  passes refill reads to the bus, prefetches the next 64-byte line
  after a line refill, and serves a matching refill from the
  local line buffer critical word first
*/
module ipb_top #(
  parameter int ADDR_W = 40,
  parameter int DATA_W = 128
) (
  input  logic              pref_clk,
  input  logic              cpurst_b,
  // refill side
  input  logic              refill_req,
  input  logic              refill_on,
  input  logic              refill_line,
  input  logic [ADDR_W-1:0] refill_addr,
  output logic              refill_grnt,
  output logic              refill_rvalid,
  output logic [DATA_W-1:0] refill_rdata,
  output logic              refill_rerr,
  // control and status
  input  logic              pref_en,
  input  logic              inv_on,
  output logic              pref_idle,
  // bus read port
  output logic              bus_req,
  output logic [ADDR_W-1:0] bus_addr,
  output logic              bus_id,
  output logic [1:0]        bus_len,
  input  logic              bus_grnt,
  input  logic              bus_rvalid,
  input  logic              bus_rid,
  input  logic              bus_rlast,
  input  logic              bus_rerr,
  input  logic [DATA_W-1:0] bus_rdata
);
  import ipb_pkg::*;

  logic                  ref_sel;
  logic                  pref_launch;
  logic                  ref_hit_pref;
  logic                  within_page;
  logic                  pref_beat;
  logic                  pref_err;
  logic                  pref_last;
  logic                  buf_wen;
  logic [BEAT_IDX_W-1:0] buf_widx;
  logic                  wb_load;
  logic                  wb_active;
  logic                  wb_step;
  logic [DATA_W-1:0]     wb_rdata;

  ipb_ctrl i_ctrl (
    .pref_clk     (pref_clk),
    .cpurst_b     (cpurst_b),
    .refill_req   (refill_req),
    .refill_on    (refill_on),
    .refill_line  (refill_line),
    .pref_en      (pref_en),
    .inv_on       (inv_on),
    .bus_grnt     (bus_grnt),
    .ref_hit_pref (ref_hit_pref),
    .within_page  (within_page),
    .pref_beat    (pref_beat),
    .pref_err     (pref_err),
    .pref_last    (pref_last),
    .ref_sel      (ref_sel),
    .bus_req      (bus_req),
    .pref_launch  (pref_launch),
    .refill_grnt  (refill_grnt),
    .buf_wen      (buf_wen),
    .buf_widx     (buf_widx),
    .wb_load      (wb_load),
    .wb_active    (wb_active),
    .wb_step      (wb_step),
    .pref_idle    (pref_idle)
  );

  ipb_addr_gen #(.ADDR_W(ADDR_W)) i_addr_gen (
    .pref_clk     (pref_clk),
    .cpurst_b     (cpurst_b),
    .refill_addr  (refill_addr),
    .refill_line  (refill_line),
    .ref_sel      (ref_sel),
    .pref_launch  (pref_launch),
    .bus_addr     (bus_addr),
    .bus_id       (bus_id),
    .bus_len      (bus_len),
    .ref_hit_pref (ref_hit_pref),
    .within_page  (within_page)
  );

  // critical beat of the refill comes from the line offset
  ipb_line_buf #(.DATA_W(DATA_W)) i_line_buf (
    .pref_clk      (pref_clk),
    .cpurst_b      (cpurst_b),
    .buf_wen       (buf_wen),
    .buf_widx      (buf_widx),
    .bus_rdata     (bus_rdata),
    .wb_load       (wb_load),
    .wb_step       (wb_step),
    .refill_offset (refill_addr[LINE_OFS_W-1:BEAT_OFS_W]),
    .wb_rdata      (wb_rdata)
  );

  ipb_resp_route #(.DATA_W(DATA_W)) i_resp_route (
    .bus_rvalid    (bus_rvalid),
    .bus_rid       (bus_rid),
    .bus_rlast     (bus_rlast),
    .bus_rerr      (bus_rerr),
    .bus_rdata     (bus_rdata),
    .wb_active     (wb_active),
    .wb_rdata      (wb_rdata),
    .pref_beat     (pref_beat),
    .pref_err      (pref_err),
    .pref_last     (pref_last),
    .refill_rvalid (refill_rvalid),
    .refill_rdata  (refill_rdata),
    .refill_rerr   (refill_rerr)
  );

endmodule

/* tests/ipb_stim.txt */
# name addr(hex) refill_line pref_en inv(0 none,1 at launch,2 after fill) pf_err_beat
# refill_err_beat cancel exp_prefetch exp_hit (error beats count from 1, 0 means none)
line_hit         0000012345 1 1 0 0 0 0 1 1
line_hit_high    abcdef0f20 1 1 0 0 0 0 1 1
near_page_end    0000400f80 1 1 0 0 0 0 1 1
page_end         1234567fc4 1 1 0 0 0 0 0 0
single_beat      0080001008 0 1 0 0 0 0 0 0
pref_disabled    0000020040 1 0 0 0 0 0 0 0
refill_error     0000030000 1 0 0 0 3 0 0 0
single_error     0000031230 0 0 0 0 1 0 0 0
inv_at_launch    0000050100 1 1 1 0 0 0 0 0
inv_after_fill   0000060200 1 1 2 0 0 0 1 0
pf_err_beat1     0000071300 1 1 0 1 0 0 1 0
pf_err_beat2     0000070300 1 1 0 2 0 0 1 0
pf_err_beat4     0000080400 1 1 0 4 0 0 1 0
cancel_other     0000090500 1 1 0 0 0 1 1 0
line_hit_again   00000a07f0 1 1 0 0 0 0 1 1
hit_after_err    00000b0800 1 1 0 0 2 0 1 1

/* tests/tb_clk_gen.sv */
/*
  testbench clock and reset
  free running clock, reset held low for a few cycles
*/
module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic pref_clk,
  output logic cpurst_b
);

  initial
  begin
    pref_clk = 1'b0;
    forever #(PERIOD / 2) pref_clk = ~pref_clk;
  end

  // release away from the active edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge pref_clk);
    @(negedge pref_clk);
    cpurst_b = 1'b1;
  end

endmodule

/* tests/tb_ipb.sv */
/*
  prefetch buffer testbench
  reads scenarios from the stimulus file, models the bus read port
  with random grant delay and random beat data, and checks refill
  pass-through, launch, local hit, cancel, error and invalidate
*/
module tb_ipb;

  localparam int ADDR_W       = 40;
  localparam int DATA_W       = 128;
  localparam int CYC_PER_TEST = 200;

  logic              pref_clk;
  logic              cpurst_b;
  logic              refill_req;
  logic              refill_on;
  logic              refill_line;
  logic [ADDR_W-1:0] refill_addr;
  logic              refill_grnt;
  logic              refill_rvalid;
  logic [DATA_W-1:0] refill_rdata;
  logic              refill_rerr;
  logic              pref_en;
  logic              inv_on;
  logic              pref_idle;
  logic              bus_req;
  logic [ADDR_W-1:0] bus_addr;
  logic              bus_id;
  logic [1:0]        bus_len;
  logic              bus_grnt;
  logic              bus_rvalid;
  logic              bus_rid;
  logic              bus_rlast;
  logic              bus_rerr;
  logic [DATA_W-1:0] bus_rdata;

  tb_clk_gen #(.PERIOD(4), .RST_CYCLES(3)) i_clk_gen (
    .pref_clk (pref_clk),
    .cpurst_b (cpurst_b)
  );

  ipb_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_dut (.*);

  //============================================================
  // testbench state
  //============================================================
  logic [31:0]       lfsr;
  int                cycles = 0;
  int                limit = CYC_PER_TEST;
  int                test_err;
  int                n_err;
  int                n_failed;
  int                n_tests;
  // values applied at the next falling edge
  logic              drv_req;
  logic [ADDR_W-1:0] drv_addr;
  logic              drv_line;
  logic              drv_pen;
  logic              drv_inv;
  // bus model
  int                gcnt;
  int                gdelay;
  logic              last_req;
  logic              last_id;
  logic              hold_pf;
  int                cur_perr;
  int                cur_rerr;
  // response entries {id, last, err, data}
  logic [DATA_W+2:0] rsp_q [$];
  // prefetched beats and expected writeback
  logic [DATA_W-1:0] pf_data [4];
  int                pf_cnt;
  int                wb_left;
  logic [1:0]        wb_ptr;
  string             stim_q [$];

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [DATA_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[DATA_W-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_val(input string sig, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s is %h, expected %h", $time, sig, got, exp);
      test_err++;
    end
  endtask

  task automatic end_test(input string nm);
    n_tests++;
    n_err += test_err;
    if (test_err != 0)
      n_failed++;
    $display("test %-16s done with %0d mismatches", nm, test_err);
  endtask

  // one or four beats with an error at the chosen beat number
  task automatic queue_burst(input logic id, input logic [1:0] len);
    logic [DATA_W-1:0] d;
    int                n;
    int                eb;
    n  = (len == 2'd3) ? 4 : 1;
    eb = id ? cur_perr : cur_rerr;
    for (int k = 0; k < n; k++)
    begin
      draw_bits(DATA_W, d);
      rsp_q.push_back({id, (k == n - 1), (k + 1 == eb), d});
    end
    if (!id)
      cur_rerr = 0;
  endtask

  //============================================================
  // one clock cycle with drive at fall and sample before rise
  //============================================================
  task automatic step();
    logic [DATA_W+2:0] rsp;
    logic [DATA_W-1:0] r;
    logic              exp_v;
    logic [DATA_W-1:0] exp_d;
    @(negedge pref_clk);
    refill_req  = drv_req;
    refill_addr = drv_addr;
    refill_line = drv_line;
    pref_en     = drv_pen;
    inv_on      = drv_inv;
    // held prefetch requests never get the grant
    bus_grnt   = last_req && (gcnt >= gdelay) && !(hold_pf && last_id);
    bus_rvalid = 1'b0;
    bus_rlast  = 1'b0;
    bus_rerr   = 1'b0;
    if (rsp_q.size() > 0)
    begin
      // random gaps between beats
      draw_bits(1, r);
      if (r[0])
      begin
        rsp = rsp_q.pop_front();
        bus_rvalid = 1'b1;
        {bus_rid, bus_rlast, bus_rerr, bus_rdata} = rsp;
      end
    end
    #1;
    // buffer beats first on the refill side, else id 0 bus beats
    if (wb_left > 0)
    begin
      exp_v = 1'b1;
      exp_d = pf_data[wb_ptr];
      wb_ptr++;
      wb_left--;
    end
    else
    begin
      exp_v = bus_rvalid && !bus_rid && !bus_rerr;
      exp_d = bus_rdata;
    end
    check_val("refill_rvalid", refill_rvalid, exp_v);
    if (exp_v)
      check_val("refill_rdata", refill_rdata, exp_d);
    check_val("refill_rerr", refill_rerr, bus_rvalid && !bus_rid && bus_rerr);
    if (bus_rvalid && bus_rid)
    begin
      if (pf_cnt < 4)
        pf_data[pf_cnt] = bus_rdata;
      pf_cnt++;
    end
    // new random grant wait per request
    if (bus_grnt)
    begin
      queue_burst(bus_id, bus_len);
      gcnt = 0;
      draw_bits(2, r);
      gdelay = r[1:0] + 1;
    end
    else if (bus_req)
      gcnt++;
    last_req = bus_req;
    last_id  = bus_id;
  endtask

  // request a refill and wait for its grant, local or from the bus
  task automatic issue_refill(input logic [ADDR_W-1:0] a, input logic line,
                              input logic local_hit);
    drv_req  = 1'b1;
    drv_addr = a;
    drv_line = line;
    step();
    while (!refill_grnt)
      step();
    if (local_hit)
    begin
      check_val("bus_grnt", bus_grnt, 1'b0);
      check_val("bus_req", bus_req, 1'b0);
      wb_ptr  = a[5:4];
      wb_left = 4;
    end
    else
    begin
      check_val("bus_grnt", bus_grnt, 1'b1);
      check_val("bus_id", bus_id, 1'b0);
      check_val("bus_addr", bus_addr, {a[ADDR_W-1:4], 4'h0});
      check_val("bus_len", bus_len, line ? 2'd3 : 2'd0);
    end
    drv_req = 1'b0;
  endtask

  //============================================================
  // one scenario line
  //============================================================
  task automatic run_test(input string ln);
    string             nm;
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] nxt;
    logic [DATA_W-1:0] r;
    int                line;
    int                pen;
    int                inv;
    int                perr;
    int                rerr;
    int                canc;
    int                xpf;
    int                xhit;
    test_err = 0;
    if ($sscanf(ln, "%s %h %d %d %d %d %d %d %d %d", nm, a, line, pen, inv,
                perr, rerr, canc, xpf, xhit) != 10)
    begin
      $display("stimulus line could not be parsed: %s", ln);
      n_failed++;
      return;
    end
    pf_cnt   = 0;
    hold_pf  = (canc != 0);
    cur_perr = perr;
    cur_rerr = rerr;
    nxt      = {a[ADDR_W-1:6] + 1'b1, 6'd0};
    drv_pen  = (pen != 0);
    drv_inv  = (inv == 1);
    issue_refill(a, line[0], 1'b0);
    drv_inv = 1'b0;
    drv_pen = 1'b0;
    // launch shows one cycle after the refill grant
    step();
    if (xpf != 0)
    begin
      check_val("bus_req", bus_req, 1'b1);
      check_val("bus_id", bus_id, 1'b1);
      check_val("bus_addr", bus_addr, nxt);
      check_val("bus_len", bus_len, 2'd3);
    end
    else
      check_val("bus_req", bus_req, 1'b0);
    if (canc != 0)
      issue_refill(nxt + 40'h40, 1'b1, 1'b0);
    else if (xpf != 0)
    begin
      while (pf_cnt < 4 || rsp_q.size() > 0)
        step();
      if (inv == 2)
      begin
        drv_inv = 1'b1;
        step();
        drv_inv = 1'b0;
        step();
        check_val("pref_idle", pref_idle, 1'b1);
      end
      // random critical beat inside the prefetched line
      draw_bits(2, r);
      issue_refill({nxt[ADDR_W-1:6], r[1:0], 4'h8}, 1'b1, xhit[0]);
    end
    // no bus request left behind the second refill
    if (canc != 0 || xpf != 0)
    begin
      step();
      check_val("bus_req", bus_req, 1'b0);
    end
    while (rsp_q.size() > 0 || wb_left > 0 || !pref_idle)
      step();
    hold_pf = 1'b0;
    end_test(nm);
  endtask

  // cycle watchdog
  always @(posedge pref_clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("timeout, the run did not finish within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //============================================================
  // main sequence
  //============================================================
  initial
  begin
    int    fd;
    string ln;
    refill_req  = 1'b0;
    refill_on   = 1'b1;
    refill_line = 1'b0;
    refill_addr = '0;
    pref_en     = 1'b0;
    inv_on      = 1'b0;
    bus_grnt    = 1'b0;
    bus_rvalid  = 1'b0;
    bus_rid     = 1'b0;
    bus_rlast   = 1'b0;
    bus_rerr    = 1'b0;
    bus_rdata   = '0;
    drv_req     = 1'b0;
    drv_addr    = '0;
    drv_line    = 1'b0;
    drv_pen     = 1'b0;
    drv_inv     = 1'b0;
    lfsr        = 32'd95;
    gcnt        = 0;
    gdelay      = 1;
    last_req    = 1'b0;
    last_id     = 1'b0;
    hold_pf     = 1'b0;
    cur_perr    = 0;
    cur_rerr    = 0;
    pf_cnt      = 0;
    wb_left     = 0;
    wb_ptr      = '0;
    n_err       = 0;
    n_failed    = 0;
    n_tests     = 0;
    fd = $fopen("tests/ipb_stim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file tests/ipb_stim.txt");
      n_failed++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        ln = "";
        void'($fgets(ln, fd));
        if (ln.len() > 1 && ln[0] != "#")
          stim_q.push_back(ln);
      end
      $fclose(fd);
    end
    limit = CYC_PER_TEST * (stim_q.size() + 1);
    // outputs while reset is held
    test_err = 0;
    step();
    check_val("bus_req", bus_req, 1'b0);
    check_val("refill_grnt", refill_grnt, 1'b0);
    check_val("pref_idle", pref_idle, 1'b1);
    end_test("reset_state");
    wait (cpurst_b);
    foreach (stim_q[i])
      run_test(stim_q[i]);
    $display("%0d tests, %0d with mismatches, %0d mismatches in all",
             n_tests, n_failed, n_err);
    if (n_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
